/* hdl/xcom_cmd_exec.sv */
`default_nettype none

module xcom_cmd_exec import xcom_pkg::*; (
   input  wire logic  c_clk_i,
   input  wire logic  c_rst_ni,
   input  wire logic  loc_req_i,
   input  wire logic  net_req_i,
   input  wire hdr_t  op_i,
   input  wire data_t dt_i,
   input  wire logic  tx_rdy_i,
   input  wire logic  rx_vld_i,
   input  wire op_t   rx_op_i,
   input  wire id_t   rx_id_i,
   input  wire data_t rx_dt_i,
   output logic       loc_ack_o,
   output logic       net_ack_o,
   output logic       tx_start_o,
   output hdr_t       tx_hdr_o,
   output logic       rdy_o,
   output logic       vld_o,
   output logic       flag_o,
   output data_t      dt1_o,
   output data_t      dt2_o,
   output id_t        id_o,
   output data_t      mem_o [MEM_DEPTH]
);

   logic  loc_ack_q, net_ack_q;
   logic  loc_exec;
   op_t   loc_op;
   logic  loc_id_en, loc_wflg_en, loc_wreg_en, loc_wmem_en;
   logic  rx_exec;
   logic  rx_no_dt, rx_wflg_en, rx_wreg_en, rx_wmem_en, rx_auto_id;
   logic  tx_auto_id;
   logic  wflg_en, wreg_en, wmem_en;
   logic  sel_bit;
   data_t wr_dt;
   id_t   mem_addr;
   logic  flag_q, wreg_q, auto_pend_q;
   data_t reg1_q, reg2_q;
   data_t mem_q [MEM_DEPTH];
   id_t   board_id_q;

   ////////////////////////////////////////////////////////////////////////////
   // Handshakes

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         loc_ack_q <= 1'b0;
         net_ack_q <= 1'b0;
      end else begin
         if (loc_req_i && !loc_ack_q) begin
            loc_ack_q <= 1'b1;
         end else if (!loc_req_i && loc_ack_q) begin
            loc_ack_q <= 1'b0;
         end
         // Network ack moves only while serializer is free
         if (net_req_i && !net_ack_q && tx_rdy_i) begin
            net_ack_q <= 1'b1;
         end else if (!net_req_i && net_ack_q && tx_rdy_i) begin
            net_ack_q <= 1'b0;
         end
      end
   end

   assign tx_start_o = net_req_i & ~net_ack_q & tx_rdy_i;
   // Sent header carries own board ID
   assign tx_hdr_o   = {op_i[7:4], board_id_q};
   assign tx_auto_id = tx_start_o & (op_i[7:4] == OP_AUTO_ID);

   ////////////////////////////////////////////////////////////////////////////
   // Decode

   // Local command executes in first req cycle
   assign loc_exec    = loc_req_i & ~loc_ack_q;
   assign loc_op      = op_i[7:4];
   assign loc_id_en   = loc_exec & (loc_op == OP_LOC_SET_ID);
   assign loc_wflg_en = loc_exec & (loc_op == OP_LOC_WFLG);
   assign loc_wreg_en = loc_exec & (loc_op == OP_LOC_WREG);
   assign loc_wmem_en = loc_exec & (loc_op == OP_LOC_WMEM);

   // Received command dropped while a local command executes
   assign rx_exec    = rx_vld_i & ~loc_exec;

   // Received opcode bits 2:1 are the header length bits
   assign rx_no_dt   = ~|rx_op_i[2:1];
   assign rx_wflg_en = rx_exec & ~rx_op_i[3] & rx_no_dt;
   assign rx_wreg_en = rx_exec & ~rx_op_i[3] & ~rx_no_dt;
   assign rx_wmem_en = rx_exec & rx_op_i[3] & ~rx_no_dt & ~rx_op_i[0];
   assign rx_auto_id = rx_exec & (rx_op_i == OP_AUTO_ID);

   // Local path wins over receive
   assign wflg_en  = loc_wflg_en | rx_wflg_en;
   assign wreg_en  = loc_wreg_en | rx_wreg_en;
   assign wmem_en  = loc_wmem_en | rx_wmem_en;
   assign sel_bit  = loc_exec ? op_i[0] : rx_op_i[0];
   assign wr_dt    = loc_exec ? dt_i : rx_dt_i;
   assign mem_addr = loc_exec ? op_i[3:0] : rx_id_i + 4'd1;

   ////////////////////////////////////////////////////////////////////////////
   // Flag, registers, memory

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         flag_q <= 1'b0;
         wreg_q <= 1'b0;
         reg1_q <= '0;
         reg2_q <= '0;
         mem_q  <= '{default: '0};
      end else begin
         wreg_q <= wreg_en;
         if (wflg_en) begin
            flag_q <= sel_bit;
         end else if (wreg_en) begin
            // Bit 0 picks the register
            if (sel_bit) begin
               reg2_q <= wr_dt;
            end else begin
               reg1_q <= wr_dt;
            end
         end else if (wmem_en && mem_addr < MEM_DEPTH) begin
            mem_q[mem_addr] <= wr_dt;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Board ID and auto-ID sequence

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         board_id_q  <= '0;
         auto_pend_q <= 1'b0;
      end else if (loc_id_en) begin
         board_id_q <= op_i[3:0];
      end else if (tx_auto_id) begin
         auto_pend_q <= 1'b1;
      end else if (rx_auto_id && auto_pend_q) begin
         // Own command returned so take previous ID plus one
         auto_pend_q <= 1'b0;
         board_id_q  <= rx_id_i + 4'd1;
      end
   end

   assign loc_ack_o = loc_ack_q;
   assign net_ack_o = net_ack_q;
   assign rdy_o     = tx_rdy_i & ~loc_req_i & ~loc_ack_q;
   assign vld_o     = wreg_q;
   assign flag_o    = flag_q;
   assign dt1_o     = reg1_q;
   assign dt2_o     = reg2_q;
   assign id_o      = board_id_q;
   assign mem_o     = mem_q;

endmodule

`default_nettype wire

/* hdl/xcom_pkg.sv */
`default_nettype none

package xcom_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Field types

   // Command opcode, upper half of a header
   typedef logic [3:0]  op_t;
   // Board ID, also used as memory address
   typedef logic [3:0]  id_t;
   // Opcode in [7:4], ID or address in [3:0], length select in [6:5]
   typedef logic [7:0]  hdr_t;
   typedef logic [31:0] data_t;
   // Serial half-period setting
   typedef logic [2:0]  tick_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_LOW,
      TX_HIGH,
      TX_GAP
   } tx_state_t;

   typedef enum logic {
      RX_HDR,
      RX_DATA
   } rx_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // Constants

   localparam int unsigned MEM_DEPTH = 15;

   // Local opcodes
   localparam op_t OP_LOC_SET_ID = 4'b0000;
   localparam op_t OP_LOC_WFLG   = 4'b0001;
   localparam op_t OP_LOC_WREG   = 4'b0010;
   localparam op_t OP_LOC_WMEM   = 4'b0011;
   // Network opcodes
   localparam op_t OP_AUTO_ID    = 4'b1001;

   // Each serial clock level lasts tick + TICK_MIN cycles
   localparam int unsigned TICK_MIN = 2;

   // Data bits in a frame, from header bits 6 and 5
   function automatic logic [5:0] data_len(input logic [1:0] len_sel);
      logic [5:0] len;
      case (len_sel)
         2'b00:   len = 6'd0;
         2'b01:   len = 6'd8;
         2'b10:   len = 6'd16;
         default: len = 6'd32;
      endcase
      return len;
   endfunction

endpackage

`default_nettype wire

/* hdl/xcom_rx_deserializer.sv */
`default_nettype none

module xcom_rx_deserializer import xcom_pkg::*; (
   input  wire logic c_clk_i,
   input  wire logic c_rst_ni,
   input  wire logic rx_dt_i,
   input  wire logic rx_ck_i,
   output logic      vld_o,
   output op_t       op_o,
   output id_t       id_o,
   output data_t     dt_o
);

   logic [1:0] dt_sync_q;
   logic [2:0] ck_sync_q;
   logic       bit_s;
   logic       rise;
   rx_state_t  state_q;
   logic [5:0] cnt_q;
   hdr_t       hdr_q;
   hdr_t       hdr_next;
   data_t      dt_q;
   logic [5:0] len;

   ////////////////////////////////////////////////////////////////////////////
   // Input synchronizers

   // Two flops on both lines, third clock flop for edge detect
   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         dt_sync_q <= '0;
         ck_sync_q <= '0;
      end else begin
         dt_sync_q <= {dt_sync_q[0], rx_dt_i};
         ck_sync_q <= {ck_sync_q[1:0], rx_ck_i};
      end
   end

   assign bit_s = dt_sync_q[1];
   assign rise  = ck_sync_q[1] & ~ck_sync_q[2];

   // Header as it will be once the current bit is in
   assign hdr_next = {hdr_q[6:0], bit_s};
   assign len      = data_len(hdr_next[6:5]);

   ////////////////////////////////////////////////////////////////////////////
   // Shift registers

   always_ff @(posedge c_clk_i) begin
      if (rise) begin
         if (state_q == RX_HDR) begin
            hdr_q <= hdr_next;
            // Clear data at header end, keeps unused bits zero
            if (cnt_q == 6'd7) begin
               dt_q <= '0;
            end
         end else begin
            dt_q <= {dt_q[30:0], bit_s};
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frame FSM

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         state_q <= RX_HDR;
         cnt_q   <= '0;
         vld_o   <= 1'b0;
      end else begin
         vld_o <= 1'b0;
         if (rise) begin
            case (state_q)
               RX_HDR: begin
                  if (cnt_q == 6'd7) begin
                     // No data bits, frame complete now
                     if (len == 6'd0) begin
                        vld_o <= 1'b1;
                        cnt_q <= '0;
                     end else begin
                        state_q <= RX_DATA;
                        cnt_q   <= len;
                     end
                  end else begin
                     cnt_q <= cnt_q + 6'd1;
                  end
               end
               default: begin
                  // Count down remaining data bits
                  if (cnt_q == 6'd1) begin
                     vld_o   <= 1'b1;
                     state_q <= RX_HDR;
                     cnt_q   <= '0;
                  end else begin
                     cnt_q <= cnt_q - 6'd1;
                  end
               end
            endcase
         end
      end
   end

   assign op_o = hdr_q[7:4];
   assign id_o = hdr_q[3:0];
   assign dt_o = dt_q;

endmodule

`default_nettype wire

/* hdl/xcom_top.sv */
`default_nettype none

module xcom_top import xcom_pkg::*; (
   input  wire logic  c_clk_i,
   input  wire logic  c_rst_ni,
   // Local command
   input  wire logic  cmd_loc_req_i,
   output logic       cmd_loc_ack_o,
   // Network command
   input  wire logic  cmd_net_req_i,
   output logic       cmd_net_ack_o,
   // Shared command fields
   input  wire hdr_t  cmd_op_i,
   input  wire data_t cmd_dt_i,
   // Serial half-period
   input  wire tick_t tick_cfg_i,
   // Serial link
   output logic       tx_dt_o,
   output logic       tx_ck_o,
   input  wire logic  rx_dt_i,
   input  wire logic  rx_ck_i,
   // Results
   output logic       qp_rdy_o,
   output logic       qp_vld_o,
   output logic       qp_flag_o,
   output data_t      qp_dt1_o,
   output data_t      qp_dt2_o,
   output id_t        xcom_id_o,
   output data_t      xcom_mem_o [MEM_DEPTH]
);

   logic  tx_rdy;
   logic  tx_start;
   hdr_t  tx_hdr;
   logic  rx_vld;
   op_t   rx_op;
   id_t   rx_id;
   data_t rx_dt;

   ////////////////////////////////////////////////////////////////////////////
   // Transmit path

   xcom_tx_serializer u_tx (
      .c_clk_i  (c_clk_i),
      .c_rst_ni (c_rst_ni),
      .start_i  (tx_start),
      .hdr_i    (tx_hdr),
      .dt_i     (cmd_dt_i),
      .tick_i   (tick_cfg_i),
      .rdy_o    (tx_rdy),
      .tx_dt_o  (tx_dt_o),
      .tx_ck_o  (tx_ck_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Receive path

   xcom_rx_deserializer u_rx (
      .c_clk_i  (c_clk_i),
      .c_rst_ni (c_rst_ni),
      .rx_dt_i  (rx_dt_i),
      .rx_ck_i  (rx_ck_i),
      .vld_o    (rx_vld),
      .op_o     (rx_op),
      .id_o     (rx_id),
      .dt_o     (rx_dt)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Command execution

   xcom_cmd_exec u_exec (
      .c_clk_i    (c_clk_i),
      .c_rst_ni   (c_rst_ni),
      .loc_req_i  (cmd_loc_req_i),
      .net_req_i  (cmd_net_req_i),
      .op_i       (cmd_op_i),
      .dt_i       (cmd_dt_i),
      .tx_rdy_i   (tx_rdy),
      .rx_vld_i   (rx_vld),
      .rx_op_i    (rx_op),
      .rx_id_i    (rx_id),
      .rx_dt_i    (rx_dt),
      .loc_ack_o  (cmd_loc_ack_o),
      .net_ack_o  (cmd_net_ack_o),
      .tx_start_o (tx_start),
      .tx_hdr_o   (tx_hdr),
      .rdy_o      (qp_rdy_o),
      .vld_o      (qp_vld_o),
      .flag_o     (qp_flag_o),
      .dt1_o      (qp_dt1_o),
      .dt2_o      (qp_dt2_o),
      .id_o       (xcom_id_o),
      .mem_o      (xcom_mem_o)
   );

endmodule

`default_nettype wire

/* hdl/xcom_tx_serializer.sv */
`default_nettype none

module xcom_tx_serializer import xcom_pkg::*; (
   input  wire logic  c_clk_i,
   input  wire logic  c_rst_ni,
   input  wire logic  start_i,
   input  wire hdr_t  hdr_i,
   input  wire data_t dt_i,
   input  wire tick_t tick_i,
   output logic       rdy_o,
   output logic       tx_dt_o,
   output logic       tx_ck_o
);

   tx_state_t   state_q;
   logic [3:0]  cnt_q;
   logic [5:0]  bits_q;
   logic [39:0] sr_q;
   tick_t       tick_q;
   logic [3:0]  half_m1;
   logic        half_end;
   logic [5:0]  len;
   data_t       dt_aligned;

   ////////////////////////////////////////////////////////////////////////////
   // Frame setup

   assign len        = data_len(hdr_i[6:5]);
   // Used data bits pushed up against the header, zeros below
   assign dt_aligned = dt_i << (6'd32 - len);

   // Last cycle of a half-period
   assign half_m1  = {1'b0, tick_q} + 4'(TICK_MIN - 1);
   assign half_end = (cnt_q == half_m1);

   // Header and data latched at start, shifted after each high half
   always_ff @(posedge c_clk_i) begin
      if (start_i && state_q == TX_IDLE) begin
         sr_q   <= {hdr_i, dt_aligned};
         tick_q <= tick_i;
      end else if (state_q == TX_HIGH && half_end) begin
         sr_q <= {sr_q[38:0], 1'b0};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bit timing FSM

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         state_q <= TX_IDLE;
         cnt_q   <= '0;
         bits_q  <= '0;
      end else begin
         // Half-period counter runs in every busy state
         if (state_q != TX_IDLE) begin
            cnt_q <= half_end ? 4'd0 : cnt_q + 4'd1;
         end
         case (state_q)
            TX_IDLE: begin
               if (start_i) begin
                  state_q <= TX_LOW;
                  cnt_q   <= '0;
                  bits_q  <= 6'd8 + len;
               end
            end
            TX_LOW: begin
               if (half_end) begin
                  state_q <= TX_HIGH;
               end
            end
            TX_HIGH: begin
               if (half_end) begin
                  // Last bit done, trailing low gap
                  if (bits_q == 6'd1) begin
                     state_q <= TX_GAP;
                  end else begin
                     state_q <= TX_LOW;
                  end
                  bits_q <= bits_q - 6'd1;
               end
            end
            default: begin
               if (half_end) begin
                  state_q <= TX_IDLE;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs

   assign rdy_o   = (state_q == TX_IDLE);
   assign tx_ck_o = (state_q == TX_HIGH);
   // Line held low while idle
   assign tx_dt_o = sr_q[39] & (state_q != TX_IDLE);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the xcom testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module xcom_tb -o xcom_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/xcom_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
echo "Simulation passed"
exit 0

/* sim.f */
hdl/xcom_pkg.sv
hdl/xcom_tx_serializer.sv
hdl/xcom_rx_deserializer.sv
hdl/xcom_cmd_exec.sv
hdl/xcom_top.sv
tests/xcom_tx_assertions.sv
tests/xcom_tb.sv

/* tests/xcom_tb.sv */
`default_nettype none

module xcom_tb import xcom_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_CMDS     = 200;
   localparam int CLK_NS       = 40;
   // Longest frame is 40 bits of two 9-cycle halves plus the gap
   localparam int FRAME_CYCLES = 40 * 2 * 9 + 9;
   localparam int WATCHDOG_NS  = (NUM_CMDS * (FRAME_CYCLES + 40) + 200) * CLK_NS;

   logic  c_clk = 1'b0;
   logic  c_rst_n;
   logic  loc_req;
   logic  net_req;
   hdr_t  cmd_op;
   data_t cmd_dt;
   tick_t tick_cfg;
   logic  loc_ack;
   logic  net_ack;
   logic  tx_dt;
   logic  tx_ck;
   logic  qp_rdy;
   logic  qp_vld;
   logic  qp_flag;
   data_t qp_dt1;
   data_t qp_dt2;
   id_t   xcom_id;
   data_t xcom_mem [MEM_DEPTH];

   // Reference model state
   logic  m_flag;
   data_t m_dt1;
   data_t m_dt2;
   data_t m_mem [MEM_DEPTH];
   id_t   m_id;
   logic  m_pend;
   logic [31:0] rng;

   always #(CLK_NS / 2) c_clk = ~c_clk;

   // Serial link looped back onto the receiver
   xcom_top UUT (
      .c_clk_i       (c_clk),
      .c_rst_ni      (c_rst_n),
      .cmd_loc_req_i (loc_req),
      .cmd_loc_ack_o (loc_ack),
      .cmd_net_req_i (net_req),
      .cmd_net_ack_o (net_ack),
      .cmd_op_i      (cmd_op),
      .cmd_dt_i      (cmd_dt),
      .tick_cfg_i    (tick_cfg),
      .tx_dt_o       (tx_dt),
      .tx_ck_o       (tx_ck),
      .rx_dt_i       (tx_dt),
      .rx_ck_i       (tx_ck),
      .qp_rdy_o      (qp_rdy),
      .qp_vld_o      (qp_vld),
      .qp_flag_o     (qp_flag),
      .qp_dt1_o      (qp_dt1),
      .qp_dt2_o      (qp_dt2),
      .xcom_id_o     (xcom_id),
      .xcom_mem_o    (xcom_mem)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] xorshift32(input logic [31:0] seed);
      logic [31:0] x;
      x = seed;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Data bits in a frame from opcode bits 2:1
   function automatic int payload_bits(input op_t op);
      case (op[2:1])
         2'b00:   return 0;
         2'b01:   return 8;
         2'b10:   return 16;
         default: return 32;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      $display("Errors found");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "Stopped at first error");
   endtask

   // Stored values against the model
   task automatic compare_state();
      assert (qp_flag == m_flag) else report_mismatch("qp_flag_o", 32'(qp_flag), 32'(m_flag));
      assert (qp_dt1 == m_dt1) else report_mismatch("qp_dt1_o", qp_dt1, m_dt1);
      assert (qp_dt2 == m_dt2) else report_mismatch("qp_dt2_o", qp_dt2, m_dt2);
      assert (xcom_id == m_id) else report_mismatch("xcom_id_o", 32'(xcom_id), 32'(m_id));
      for (int i = 0; i < MEM_DEPTH; i++) begin
         assert (xcom_mem[i] == m_mem[i])
            else report_mismatch($sformatf("xcom_mem_o[%0d]", i), xcom_mem[i], m_mem[i]);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Local command

   task automatic issue_local(input hdr_t op, input data_t dt);
      int   wait_cnt;
      logic exp_vld;
      exp_vld = (op[7:4] == OP_LOC_WREG);
      @(posedge c_clk);
      loc_req <= 1'b1;
      cmd_op  <= op;
      cmd_dt  <= dt;
      // Execute cycle with ack still low
      @(negedge c_clk);
      assert (!loc_ack) else report_mismatch("cmd_loc_ack_o", 32'(loc_ack), 32'd0);
      @(negedge c_clk);
      assert (loc_ack) else report_mismatch("cmd_loc_ack_o", 32'(loc_ack), 32'd1);
      assert (qp_vld == exp_vld) else report_mismatch("qp_vld_o", 32'(qp_vld), 32'(exp_vld));
      case (op[7:4])
         OP_LOC_SET_ID: m_id = op[3:0];
         OP_LOC_WFLG:   m_flag = op[0];
         OP_LOC_WREG: begin
            if (op[0]) begin
               m_dt2 = dt;
            end else begin
               m_dt1 = dt;
            end
         end
         OP_LOC_WMEM: begin
            // Address 15 has no word behind it
            if (op[3:0] < MEM_DEPTH) begin
               m_mem[op[3:0]] = dt;
            end
         end
         default: ;
      endcase
      compare_state();
      @(posedge c_clk);
      loc_req <= 1'b0;
      wait_cnt = 0;
      @(negedge c_clk);
      while (loc_ack) begin
         wait_cnt++;
         if (wait_cnt > 4) begin
            abort_run("Local ack did not fall after req was dropped");
         end
         @(negedge c_clk);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Network command measured on the wire and checked after loopback

   task automatic send_network(input hdr_t op, input data_t dt, input tick_t tick);
      int    half;
      int    bits;
      int    run;
      int    rises;
      int    cyc;
      int    wait_cnt;
      logic  prev_ck;
      op_t   nop;
      id_t   sent_id;
      id_t   addr;
      data_t pay;
      nop     = op[7:4];
      half    = int'(tick) + 2;
      bits    = payload_bits(nop);
      pay     = (bits == 32) ? dt : dt & ((32'd1 << bits) - 32'd1);
      sent_id = m_id;
      @(posedge c_clk);
      net_req <= 1'b1;
      cmd_op  <= op;
      cmd_dt  <= dt;
      wait_cnt = 0;
      @(negedge c_clk);
      while (!net_ack) begin
         wait_cnt++;
         if (wait_cnt > 4) begin
            abort_run("Network ack did not rise while the serializer was ready");
         end
         @(negedge c_clk);
      end
      assert (wait_cnt == 1) else report_mismatch("cmd_net_ack_o delay", wait_cnt, 32'd1);
      assert (!qp_rdy) else report_mismatch("qp_rdy_o", 32'(qp_rdy), 32'd0);
      if (nop == OP_AUTO_ID) begin
         m_pend = 1'b1;
      end
      // First low cycle of the first bit already seen here
      run     = 1;
      rises   = 0;
      cyc     = 0;
      prev_ck = tx_ck;
      @(posedge c_clk);
      net_req <= 1'b0;
      @(negedge c_clk);
      while (!qp_rdy) begin
         assert (net_ack) else abort_run("Network ack fell before the frame ended");
         if (tx_ck == prev_ck) begin
            run++;
         end else begin
            assert (run == half)
               else report_mismatch(prev_ck ? "tx_ck_o high half" : "tx_ck_o low half",
                                    run, half);
            if (tx_ck) begin
               rises++;
            end
            run     = 1;
            prev_ck = tx_ck;
         end
         cyc++;
         if (cyc > FRAME_CYCLES + 20) begin
            abort_run("Serializer did not return to ready");
         end
         @(negedge c_clk);
      end
      // Trailing gap is one more low half
      assert (!prev_ck && run == half) else report_mismatch("tx_ck_o gap", run, half);
      assert (rises == 8 + bits) else report_mismatch("tx_ck_o rising edges", rises, 8 + bits);
      wait_cnt = 0;
      while (net_ack) begin
         wait_cnt++;
         if (wait_cnt > 4) begin
            abort_run("Network ack did not fall after the frame ended");
         end
         @(negedge c_clk);
      end
      // Receive decode of the returned frame
      if (nop == OP_AUTO_ID) begin
         if (m_pend) begin
            m_id   = sent_id + 4'd1;
            m_pend = 1'b0;
         end
      end else if (!nop[3] && bits == 0) begin
         m_flag = nop[0];
      end else if (!nop[3]) begin
         if (nop[0]) begin
            m_dt2 = pay;
         end else begin
            m_dt1 = pay;
         end
      end else if (bits != 0 && !nop[0]) begin
         addr = sent_id + 4'd1;
         if (addr < MEM_DEPTH) begin
            m_mem[addr] = pay;
         end
      end
      compare_state();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      hdr_t  op;
      data_t dt;
      tick_t tick_val;
      c_rst_n  = 1'b0;
      loc_req  = 1'b0;
      net_req  = 1'b0;
      cmd_op   = '0;
      cmd_dt   = '0;
      tick_cfg = '0;
      tick_val = '0;
      m_flag   = 1'b0;
      m_dt1    = '0;
      m_dt2    = '0;
      m_id     = '0;
      m_pend   = 1'b0;
      for (int i = 0; i < MEM_DEPTH; i++) begin
         m_mem[i] = '0;
      end
      rng = 32'd78526;
      repeat (10) @(posedge c_clk);
      c_rst_n <= 1'b1;
      @(negedge c_clk);
      // Reset state
      assert (!loc_ack) else report_mismatch("cmd_loc_ack_o", 32'(loc_ack), 32'd0);
      assert (!net_ack) else report_mismatch("cmd_net_ack_o", 32'(net_ack), 32'd0);
      assert (!qp_vld) else report_mismatch("qp_vld_o", 32'(qp_vld), 32'd0);
      assert (qp_rdy) else report_mismatch("qp_rdy_o", 32'(qp_rdy), 32'd1);
      compare_state();
      for (int n = 0; n < NUM_CMDS; n++) begin
         // New half-period every eight commands
         if (n % 8 == 0) begin
            rng      = xorshift32(rng);
            tick_val = rng[2:0];
            @(posedge c_clk);
            tick_cfg <= tick_val;
         end
         rng = xorshift32(rng);
         op  = rng[15:8];
         rng = xorshift32(rng);
         dt  = rng;
         if (op[0] ^ op[5] ^ dt[9]) begin
            send_network(op, dt, tick_val);
         end else begin
            // Local opcodes 0000 to 0011
            op[7:6] = 2'b00;
            issue_local(op, dt);
         end
      end
      $display("No errors");
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      abort_run("Timeout while the command sequence was still running");
   end

endmodule

`default_nettype wire

/* tests/xcom_tx_assertions.sv */
`default_nettype none

module xcom_tx_assertions (
   input wire logic c_clk_i,
   input wire logic c_rst_ni,
   input wire logic rdy_o,
   input wire logic tx_dt_o,
   input wire logic tx_ck_o
);

   timeunit 1ns;
   timeprecision 1ps;

   ////////////////////////////////////////////////////////////////////////////
   // Serializer properties

   // Idle on the first cycle out of reset
   a_rdy_after_reset: assert property (@(posedge c_clk_i) $rose(c_rst_ni) |-> rdy_o)
      else $error("Serializer not ready on the first cycle after reset");

   // Serial clock parked low while idle
   a_ck_low_idle: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
      rdy_o |-> !tx_ck_o)
      else $error("Serial clock high while the serializer is idle");

   // Data moves only in the low half
   a_dt_stable_high: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
      tx_ck_o |-> $stable(tx_dt_o))
      else $error("Serial data changed while the serial clock was high");

endmodule

bind xcom_tx_serializer xcom_tx_assertions u_tx_sva (
   .c_clk_i  (c_clk_i),
   .c_rst_ni (c_rst_ni),
   .rdy_o    (rdy_o),
   .tx_dt_o  (tx_dt_o),
   .tx_ck_o  (tx_ck_o)
);

`default_nettype wire
